// File: logic/emu_bus_pkg.sv
`default_nettype none

package emu_bus_pkg;

    // Register bus geometry
    localparam int CSR_ADDR_W = 12;
    localparam int CSR_DATA_W = 32;
    localparam int CSR_STRB_W = 4;

    // Write and read response codes
    localparam logic [1:0] RESP_OKAY   = 2'b00;
    localparam logic [1:0] RESP_SLVERR = 2'b10;

    // Host side of the register bus
    typedef struct packed {
        logic                  awvalid;
        logic [CSR_ADDR_W-1:0] awaddr;
        logic                  wvalid;
        logic [CSR_DATA_W-1:0] wdata;
        logic [CSR_STRB_W-1:0] wstrb;
        logic                  bready;
        logic                  arvalid;
        logic [CSR_ADDR_W-1:0] araddr;
        logic                  rready;
    } axil_req_t;

    // Slave side of the register bus
    typedef struct packed {
        logic                  awready;
        logic                  wready;
        logic                  bvalid;
        logic [1:0]            bresp;
        logic                  arready;
        logic                  rvalid;
        logic [1:0]            rresp;
        logic [CSR_DATA_W-1:0] rdata;
    } axil_rsp_t;

    // One accepted register write, valid for a single cycle
    typedef struct packed {
        logic                  valid;
        logic [CSR_ADDR_W-1:0] addr;
        logic [CSR_DATA_W-1:0] data;
    } csr_wr_t;

endpackage

`default_nettype wire

// File: logic/emu_csr_pkg.sv
`default_nettype none

package emu_csr_pkg;

    // Register map
    localparam logic [emu_bus_pkg::CSR_ADDR_W-1:0] REG_STAT      = 'h000;
    localparam logic [emu_bus_pkg::CSR_ADDR_W-1:0] REG_TRIG_STAT = 'h004;
    localparam logic [emu_bus_pkg::CSR_ADDR_W-1:0] REG_CYCLE_LO  = 'h008;
    localparam logic [emu_bus_pkg::CSR_ADDR_W-1:0] REG_CYCLE_HI  = 'h00C;
    localparam logic [emu_bus_pkg::CSR_ADDR_W-1:0] REG_STEP      = 'h010;

    // STAT bit positions, bit 31 is read only
    localparam int STAT_PAUSE_BIT     = 0;
    localparam int STAT_DUT_RESET_BIT = 1;
    localparam int STAT_STEP_TRIG_BIT = 31;

    // Design comes up held: paused and in reset
    localparam logic RST_PAUSE     = 1'b1;
    localparam logic RST_DUT_RESET = 1'b1;

    localparam int TRIG_W = 32;

    typedef struct packed {
        logic [31:0] hi;
        logic [31:0] lo;
    } cycle_halves_t;

    // Counter as one count, or as the two register halves
    typedef union packed {
        logic [63:0]   count;
        cycle_halves_t half;
    } emu_cycle_u;

endpackage

`default_nettype wire

// File: logic/csr_write_port.sv
`timescale 1ns/1ps
`default_nettype none

module csr_write_port (
    input  logic                                 clk,
    input  logic                                 rst,
    input  logic                                 awvalid,
    input  logic [emu_bus_pkg::CSR_ADDR_W-1:0]   awaddr,
    input  logic                                 wvalid,
    input  logic [emu_bus_pkg::CSR_DATA_W-1:0]   wdata,
    input  logic [emu_bus_pkg::CSR_STRB_W-1:0]   wstrb,
    input  logic                                 bready,
    output logic                                 awready,
    output logic                                 wready,
    output logic                                 bvalid,
    output logic [1:0]                           bresp,
    output emu_bus_pkg::csr_wr_t                 wr
);
    import emu_bus_pkg::*;

    logic [CSR_ADDR_W-1:0] addr_q;
    logic [CSR_DATA_W-1:0] data_q;
    logic                  addr_held;
    logic                  data_held;
    logic                  strb_err;
    logic                  resp_pend;
    logic                  resp_err;
    logic                  both_held;

    assign both_held = addr_held && data_held;

    always_ff @(posedge clk) begin
        if (awvalid && awready) begin
            addr_q <= awaddr;
        end
        if (wvalid && wready) begin
            data_q <= wdata;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            addr_held <= 1'b0;
            data_held <= 1'b0;
            strb_err  <= 1'b0;
            resp_pend <= 1'b0;
            resp_err  <= 1'b0;
        end else begin
            if (awvalid && awready) begin
                addr_held <= 1'b1;
            end
            if (wvalid && wready) begin
                data_held <= 1'b1;
                strb_err  <= (wstrb != '1);
            end
            if (bvalid && bready) begin
                resp_pend <= 1'b0;
            end
            // Pair complete, the write lands at this edge
            if (both_held) begin
                addr_held <= 1'b0;
                data_held <= 1'b0;
                resp_pend <= 1'b1;
                resp_err  <= strb_err;
            end
        end
    end

    assign awready = !addr_held && !resp_pend;
    assign wready  = !data_held;
    assign bvalid  = resp_pend;
    // Separate copy so a new data beat cannot disturb a pending response
    assign bresp   = resp_err ? RESP_SLVERR : RESP_OKAY;

    assign wr = '{valid: both_held && !strb_err, addr: addr_q, data: data_q};

endmodule

`default_nettype wire

// File: logic/csr_read_port.sv
`timescale 1ns/1ps
`default_nettype none

module csr_read_port (
    input  logic                                 clk,
    input  logic                                 rst,
    input  logic                                 arvalid,
    input  logic [emu_bus_pkg::CSR_ADDR_W-1:0]   araddr,
    input  logic                                 rready,
    input  logic [emu_bus_pkg::CSR_DATA_W-1:0]   rd_data,
    output logic                                 arready,
    output logic                                 rvalid,
    output logic [emu_bus_pkg::CSR_DATA_W-1:0]   rdata,
    output logic [1:0]                           rresp,
    output logic [emu_bus_pkg::CSR_ADDR_W-1:0]   rd_addr
);
    import emu_bus_pkg::*;

    logic addr_held;
    logic data_held;

    always_ff @(posedge clk) begin
        if (arvalid && arready) begin
            rd_addr <= araddr;
        end
        // Sample the register one edge after the address is taken
        if (addr_held && !data_held) begin
            rdata <= rd_data;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            addr_held <= 1'b0;
            data_held <= 1'b0;
        end else begin
            if (arvalid && arready) begin
                addr_held <= 1'b1;
            end
            if (addr_held && !data_held) begin
                data_held <= 1'b1;
            end
            if (rvalid && rready) begin
                addr_held <= 1'b0;
                data_held <= 1'b0;
            end
        end
    end

    // Only one read in flight
    assign arready = !addr_held;
    assign rvalid  = data_held;
    assign rresp   = RESP_OKAY;

endmodule

`default_nettype wire

// File: logic/emu_run_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module emu_run_ctrl (
    input  logic                                 clk,
    input  logic                                 rst,
    input  logic                                 stat_we,
    input  logic                                 step_we,
    input  logic [emu_bus_pkg::CSR_DATA_W-1:0]   wdata,
    input  logic [emu_csr_pkg::TRIG_W-1:0]       dut_trig,
    output logic                                 paused,
    output logic                                 dut_reset,
    output logic                                 step_trig,
    output logic [emu_csr_pkg::TRIG_W-1:0]       trig_stat,
    output logic [emu_bus_pkg::CSR_DATA_W-1:0]   step
);
    import emu_bus_pkg::*;
    import emu_csr_pkg::*;

    logic [CSR_DATA_W-1:0] step_next;
    logic                  step_hit;
    logic                  trigger;

    // Countdown only advances while the design runs
    always_comb begin
        if (paused) begin
            step_next = step;
        end else if (step != '0) begin
            step_next = step - 1'b1;
        end else begin
            step_next = '0;
        end
    end

    // Step reaches zero from 1 on this cycle
    assign step_hit = (step != '0) && (step_next == '0);
    assign trigger  = step_hit || (|dut_trig);

    always_ff @(posedge clk) begin
        if (rst) begin
            paused    <= RST_PAUSE;
            dut_reset <= RST_DUT_RESET;
            step_trig <= 1'b0;
            trig_stat <= '0;
        end else if (trigger) begin
            // Trigger wins over a STAT write in the same cycle
            paused    <= 1'b1;
            step_trig <= step_hit;
            trig_stat <= dut_trig;
        end else if (stat_we) begin
            paused    <= wdata[STAT_PAUSE_BIT];
            dut_reset <= wdata[STAT_DUT_RESET_BIT];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            step <= '0;
        end else if (step_we) begin
            step <= wdata;
        end else begin
            step <= step_next;
        end
    end

endmodule

`default_nettype wire

// File: logic/emu_cycle_counter.sv
`timescale 1ns/1ps
`default_nettype none

module emu_cycle_counter (
    input  logic                                 clk,
    input  logic                                 rst,
    input  logic                                 paused,
    input  logic                                 lo_we,
    input  logic                                 hi_we,
    input  logic [emu_bus_pkg::CSR_DATA_W-1:0]   wdata,
    output emu_csr_pkg::emu_cycle_u              cycle
);

    always_ff @(posedge clk) begin
        if (rst) begin
            cycle.count <= '0;
        end else if (!paused) begin
            cycle.count <= cycle.count + 64'd1;
        end else begin
            // Presets are ignored while running
            if (lo_we) begin
                cycle.half.lo <= wdata;
            end
            if (hi_we) begin
                cycle.half.hi <= wdata;
            end
        end
    end

endmodule

`default_nettype wire

// File: logic/emu_csr_file.sv
`timescale 1ns/1ps
`default_nettype none

module emu_csr_file (
    input  logic                                 clk,
    input  logic                                 rst,
    input  emu_bus_pkg::csr_wr_t                 wr,
    input  logic [emu_bus_pkg::CSR_ADDR_W-1:0]   rd_addr,
    input  logic [emu_csr_pkg::TRIG_W-1:0]       dut_trig,
    output logic [emu_bus_pkg::CSR_DATA_W-1:0]   rd_data,
    output logic                                 dut_pause,
    output logic                                 dut_reset
);
    import emu_bus_pkg::*;
    import emu_csr_pkg::*;

    logic                  stat_we;
    logic                  step_we;
    logic                  lo_we;
    logic                  hi_we;
    logic                  paused;
    logic                  step_trig;
    logic [TRIG_W-1:0]     trig_stat;
    logic [CSR_DATA_W-1:0] step;
    logic [CSR_DATA_W-1:0] stat_word;
    emu_cycle_u            cycle;

    // Per-register write strobes
    assign stat_we = wr.valid && (wr.addr == REG_STAT);
    assign step_we = wr.valid && (wr.addr == REG_STEP);
    assign lo_we   = wr.valid && (wr.addr == REG_CYCLE_LO);
    assign hi_we   = wr.valid && (wr.addr == REG_CYCLE_HI);

    emu_run_ctrl u_run_ctrl (
        .clk       (clk),
        .rst       (rst),
        .stat_we   (stat_we),
        .step_we   (step_we),
        .wdata     (wr.data),
        .dut_trig  (dut_trig),
        .paused    (paused),
        .dut_reset (dut_reset),
        .step_trig (step_trig),
        .trig_stat (trig_stat),
        .step      (step)
    );

    emu_cycle_counter u_cycle_counter (
        .clk    (clk),
        .rst    (rst),
        .paused (paused),
        .lo_we  (lo_we),
        .hi_we  (hi_we),
        .wdata  (wr.data),
        .cycle  (cycle)
    );

    always_comb begin
        stat_word                     = '0;
        stat_word[STAT_PAUSE_BIT]     = paused;
        stat_word[STAT_DUT_RESET_BIT] = dut_reset;
        stat_word[STAT_STEP_TRIG_BIT] = step_trig;
    end

    // Unmapped offsets read as zero
    always_comb begin
        case (rd_addr)
            REG_STAT:      rd_data = stat_word;
            REG_TRIG_STAT: rd_data = trig_stat;
            REG_CYCLE_LO:  rd_data = cycle.half.lo;
            REG_CYCLE_HI:  rd_data = cycle.half.hi;
            REG_STEP:      rd_data = step;
            default:       rd_data = '0;
        endcase
    end

    assign dut_pause = paused;

endmodule

`default_nettype wire

// File: logic/emu_ctrl_top.sv
`timescale 1ns/1ps
`default_nettype none

module emu_ctrl_top (
    input  logic                             clk,
    input  logic                             rst,
    input  emu_bus_pkg::axil_req_t           bus_req,
    output emu_bus_pkg::axil_rsp_t           bus_rsp,
    input  logic [emu_csr_pkg::TRIG_W-1:0]   dut_trig,
    output logic                             dut_pause,
    output logic                             dut_reset
);
    import emu_bus_pkg::*;

    csr_wr_t               wr;
    logic [CSR_ADDR_W-1:0] rd_addr;
    logic [CSR_DATA_W-1:0] rd_data;

    csr_write_port u_write_port (
        .clk     (clk),
        .rst     (rst),
        .awvalid (bus_req.awvalid),
        .awaddr  (bus_req.awaddr),
        .wvalid  (bus_req.wvalid),
        .wdata   (bus_req.wdata),
        .wstrb   (bus_req.wstrb),
        .bready  (bus_req.bready),
        .awready (bus_rsp.awready),
        .wready  (bus_rsp.wready),
        .bvalid  (bus_rsp.bvalid),
        .bresp   (bus_rsp.bresp),
        .wr      (wr)
    );

    csr_read_port u_read_port (
        .clk     (clk),
        .rst     (rst),
        .arvalid (bus_req.arvalid),
        .araddr  (bus_req.araddr),
        .rready  (bus_req.rready),
        .rd_data (rd_data),
        .arready (bus_rsp.arready),
        .rvalid  (bus_rsp.rvalid),
        .rdata   (bus_rsp.rdata),
        .rresp   (bus_rsp.rresp),
        .rd_addr (rd_addr)
    );

    emu_csr_file u_csr_file (
        .clk       (clk),
        .rst       (rst),
        .wr        (wr),
        .rd_addr   (rd_addr),
        .dut_trig  (dut_trig),
        .rd_data   (rd_data),
        .dut_pause (dut_pause),
        .dut_reset (dut_reset)
    );

endmodule

`default_nettype wire

// File: verification/emu_ctrl_tb.sv
`timescale 1ns/1ps
`default_nettype none

module emu_ctrl_tb;
    import emu_bus_pkg::*;
    import emu_csr_pkg::*;

    localparam int HS_LIMIT    = 50;
    localparam int PAUSE_LIMIT = 400;

    logic              clk;
    logic              rst;
    axil_req_t         bus_req;
    axil_rsp_t         bus_rsp;
    logic [TRIG_W-1:0] dut_trig;
    logic              dut_pause;
    logic              dut_reset;

    integer seed = 32'h913e;
    int     checks;
    int     mismatches;
    int     failures;

    emu_ctrl_top u_dut (
        .clk       (clk),
        .rst       (rst),
        .bus_req   (bus_req),
        .bus_rsp   (bus_rsp),
        .dut_trig  (dut_trig),
        .dut_pause (dut_pause),
        .dut_reset (dut_reset)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // Inputs change and outputs are sampled 1 ns after the rising edge
    task automatic tick();
        @(posedge clk);
        #1;
    endtask

    task automatic check(input string name, input logic [31:0] actual,
                         input logic [31:0] expected);
        checks++;
        if (actual !== expected) begin
            mismatches++;
            $display("FAILED time=%0t signal=%s actual=%h expected=%h",
                     $time, name, actual, expected);
        end
    endtask

    task automatic bus_write(input logic [CSR_ADDR_W-1:0] addr, input logic [31:0] data,
                             input logic [3:0] strb, input logic [1:0] exp_resp);
        int   waited;
        int   hold;
        logic aw_hit;
        logic w_hit;
        bus_req.awvalid = 1'b1;
        bus_req.awaddr  = addr;
        bus_req.wvalid  = 1'b1;
        bus_req.wdata   = data;
        bus_req.wstrb   = strb;
        waited = 0;
        while ((bus_req.awvalid || bus_req.wvalid) && waited < HS_LIMIT) begin
            aw_hit = bus_req.awvalid && bus_rsp.awready;
            w_hit  = bus_req.wvalid && bus_rsp.wready;
            tick();
            if (aw_hit) begin
                bus_req.awvalid = 1'b0;
            end
            if (w_hit) begin
                bus_req.wvalid = 1'b0;
                // Data is held now, so the data channel must be closed
                check("wready", {31'd0, bus_rsp.wready}, 32'd0);
            end
            waited++;
        end
        if (bus_req.awvalid || bus_req.wvalid) begin
            failures++;
            $display("ERROR time=%0t write to %h was never accepted", $time, addr);
            bus_req.awvalid = 1'b0;
            bus_req.wvalid  = 1'b0;
        end
        // No new address may be taken while the response is held back
        hold = 1 + ($random(seed) & 3);
        repeat (hold) begin
            tick();
            if (bus_rsp.bvalid) begin
                check("awready", {31'd0, bus_rsp.awready}, 32'd0);
            end
        end
        bus_req.bready = 1'b1;
        waited = 0;
        while (!bus_rsp.bvalid && waited < HS_LIMIT) begin
            tick();
            waited++;
        end
        if (bus_rsp.bvalid) begin
            check("bresp", {30'd0, bus_rsp.bresp}, {30'd0, exp_resp});
            tick();
        end else begin
            failures++;
            $display("ERROR time=%0t write to %h got no response", $time, addr);
        end
        bus_req.bready = 1'b0;
    endtask

    task automatic bus_read(input logic [CSR_ADDR_W-1:0] addr, input logic [31:0] expected);
        int          waited;
        int          hold;
        logic [31:0] first;
        bus_req.arvalid = 1'b1;
        bus_req.araddr  = addr;
        waited = 0;
        while (!bus_rsp.arready && waited < HS_LIMIT) begin
            tick();
            waited++;
        end
        if (!bus_rsp.arready) begin
            failures++;
            $display("ERROR time=%0t read of %h was never accepted", $time, addr);
            bus_req.arvalid = 1'b0;
        end else begin
            tick();
            bus_req.arvalid = 1'b0;
            waited = 0;
            while (!bus_rsp.rvalid && waited < HS_LIMIT) begin
                tick();
                waited++;
            end
            if (!bus_rsp.rvalid) begin
                failures++;
                $display("ERROR time=%0t read of %h returned no data", $time, addr);
            end else begin
                first = bus_rsp.rdata;
                hold  = 1 + ($random(seed) & 3);
                repeat (hold) begin
                    tick();
                    check("rvalid", {31'd0, bus_rsp.rvalid}, 32'd1);
                    check("rdata_hold", bus_rsp.rdata, first);
                    check("arready", {31'd0, bus_rsp.arready}, 32'd0);
                end
                check("rdata", bus_rsp.rdata, expected);
                check("rresp", {30'd0, bus_rsp.rresp}, {30'd0, RESP_OKAY});
                // The status pins follow the STAT bits
                if (addr == REG_STAT) begin
                    check("dut_pause", {31'd0, dut_pause},
                          {31'd0, expected[STAT_PAUSE_BIT]});
                    check("dut_reset", {31'd0, dut_reset},
                          {31'd0, expected[STAT_DUT_RESET_BIT]});
                end
                bus_req.rready = 1'b1;
                tick();
                bus_req.rready = 1'b0;
            end
        end
    endtask

    task automatic pulse_trigger(input logic [TRIG_W-1:0] value);
        dut_trig = value;
        tick();
        dut_trig = '0;
    endtask

    task automatic wait_for_pause();
        int waited;
        waited = 0;
        while (!dut_pause && waited < PAUSE_LIMIT) begin
            tick();
            waited++;
        end
        if (!dut_pause) begin
            failures++;
            $display("ERROR time=%0t design never paused", $time);
        end
    endtask

    initial begin
        int          fd;
        int          rc;
        int          ch;
        int          cycles;
        logic [7:0]  cmd;
        logic [31:0] a_val;
        logic [31:0] d_val;
        logic [31:0] s_val;
        logic [31:0] r_val;
        logic        at_end;
        rst        = 1'b1;
        bus_req    = '0;
        dut_trig   = '0;
        checks     = 0;
        mismatches = 0;
        failures   = 0;
        repeat (16) @(posedge clk);
        #1;
        rst = 1'b0;
        tick();

        fd = $fopen("verification/emu_stim.txt", "r");
        if (fd == 0) begin
            failures++;
            $display("ERROR could not open the stimulus file");
        end else begin
            at_end = 1'b0;
            while (!at_end) begin
                rc = $fscanf(fd, "%s", cmd);
                if (rc != 1) begin
                    at_end = 1'b1;
                end else if (cmd == "#") begin
                    ch = $fgetc(fd);
                    while (ch != 10 && ch != -1) begin
                        ch = $fgetc(fd);
                    end
                end else if (cmd == "W") begin
                    rc = $fscanf(fd, "%h %h %h %h", a_val, d_val, s_val, r_val);
                    bus_write(a_val[CSR_ADDR_W-1:0], d_val, s_val[3:0], r_val[1:0]);
                end else if (cmd == "R") begin
                    rc = $fscanf(fd, "%h %h", a_val, d_val);
                    bus_read(a_val[CSR_ADDR_W-1:0], d_val);
                end else if (cmd == "T") begin
                    rc = $fscanf(fd, "%h", d_val);
                    pulse_trigger(d_val);
                end else if (cmd == "P") begin
                    wait_for_pause();
                end else if (cmd == "I") begin
                    rc = $fscanf(fd, "%d", cycles);
                    repeat (cycles) tick();
                end else begin
                    failures++;
                    $display("ERROR unknown command in the stimulus file");
                end
            end
            $fclose(fd);
        end

        $display("checks=%0d mismatches=%0d other_errors=%0d", checks, mismatches, failures);
        if (mismatches == 0 && failures == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: sim.f
logic/emu_bus_pkg.sv
logic/emu_csr_pkg.sv
logic/csr_write_port.sv
logic/csr_read_port.sv
logic/emu_run_ctrl.sv
logic/emu_cycle_counter.sv
logic/emu_csr_file.sv
logic/emu_ctrl_top.sv
verification/emu_ctrl_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the emulation controller testbench with Verilator
set -e

cd "$(dirname "$0")"
rm -rf obj_dir sim.log

verilator --binary --timing -f sim.f --top-module emu_ctrl_tb -o emu_ctrl_sim
./obj_dir/emu_ctrl_sim > sim.log 2>&1
cat sim.log

if grep -q "^STATUS: PASS$" sim.log; then
    exit 0
else
    echo "simulation reported a failure, see sim.log"
    exit 1
fi

// File: verification/emu_stim.txt
# Columns: W addr data strb bresp | R addr data | T trig | P | I cycles
# Values are hex except the I cycle count, which is decimal
# Reset state and an unmapped offset
R 000 00000003
R 004 00000000
R 008 00000000
R 00C 00000000
R 010 00000000
R 100 00000000
# Partial strobes get SLVERR and write nothing
W 010 12345678 3 2
R 010 00000000
W 000 00000000 1 2
R 000 00000003
W 010 000000AB F 0
R 010 000000AB
W 020 DEADBEEF F 0
R 020 00000000
# Preset the cycle counter while paused
W 008 FFFFFFF0 F 0
W 00C 00000005 F 0
R 008 FFFFFFF0
R 00C 00000005
# Run 32 steps, low half carries into the high half
W 010 00000020 F 0
W 000 00000000 F 0
P
R 008 00000010
R 00C 00000006
R 010 00000000
R 000 80000001
R 004 00000000
# Free run stopped by a design trigger
W 000 00000000 F 0
I 5
T 00A50001
P
R 004 00A50001
R 000 00000001
# Run with design reset held, stop on the top trigger line
W 000 00000002 F 0
R 000 00000002
T 80000000
P
R 004 80000000
R 000 00000003
